// ==== Makefile ====
TOP := tb_cpu_on_board

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q '^ALL TESTS PASSED$$'

clean:
	rm -rf obj_dir

// ==== design/board_bus_ctrl.sv ====
`timescale 1ns/1ps

module board_bus_ctrl (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  soc_map_pkg::addr_t     bus_address,
    input  soc_map_pkg::dword_t    bus_write_data,
    input  logic                   bus_write_enable,
    input  logic                   bus_read_enable,
    input  periph_pkg::byte_t      last_code,
    input  logic                   busy,
    output soc_map_pkg::dword_t    bus_read_data,
    output logic                   key_sel,
    output periph_pkg::byte_t      tx_byte,
    output logic                   tx_start,
    data_bus_if.master             mem
);

    localparam int IDX_W = $bits(soc_map_pkg::word_idx_t);

    logic               mem_sel;
    logic               tx_data_sel;
    logic               stat_sel;
    logic               tx_wr;
    logic               tx_wr_q;
    logic               rd_mem_q;
    logic               rd_periph_q;
    soc_map_pkg::word_t periph_q;
    soc_map_pkg::word_t rd_word;

    // Address decode
    assign mem_sel     = (bus_address < soc_map_pkg::MEM_LIMIT);
    assign key_sel     = (bus_address == soc_map_pkg::KEY_ADDR);
    assign tx_data_sel = (bus_address == soc_map_pkg::UART_DATA_ADDR);
    assign stat_sel    = (bus_address == soc_map_pkg::UART_STAT_ADDR);

    // Memory accesses go out as word indices
    assign mem.word_idx = bus_address[IDX_W+1:2];
    assign mem.wdata    = bus_write_data[31:0];
    assign mem.we       = bus_write_enable && mem_sel;
    assign mem.re       = bus_read_enable && mem_sel;

    // Region and peripheral value are captured with the read
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_mem_q    <= 1'b0;
            rd_periph_q <= 1'b0;
            periph_q    <= '0;
        end else if (bus_read_enable) begin
            rd_mem_q    <= mem_sel;
            rd_periph_q <= key_sel || stat_sel;
            if (key_sel) begin
                periph_q <= {24'd0, last_code};
            end else begin
                periph_q <= {31'd0, busy};
            end
        end
    end

    always_comb begin
        if (rd_mem_q) begin
            rd_word = mem.rdata;
        end else if (rd_periph_q) begin
            rd_word = periph_q;
        end else begin
            rd_word = '0;
        end
    end

    assign bus_read_data = {32'd0, rd_word};

    // Only the first cycle of a run of serial writes counts
    assign tx_wr = bus_write_enable && tx_data_sel;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tx_wr_q <= 1'b0;
        end else begin
            tx_wr_q <= tx_wr;
        end
    end

    // Dropped while a frame is on the line
    assign tx_start = tx_wr && !tx_wr_q && !busy;
    assign tx_byte  = bus_write_data[7:0];

endmodule

// ==== design/cpu_on_board.sv ====
`timescale 1ns/1ps

module cpu_on_board (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                PS2_CLK,
    input  logic                PS2_DAT,
    input  soc_map_pkg::addr_t  fetch_pc,
    output soc_map_pkg::word_t  instr,
    input  soc_map_pkg::addr_t  bus_address,
    input  soc_map_pkg::dword_t bus_write_data,
    input  logic                bus_write_enable,
    input  logic                bus_read_enable,
    output soc_map_pkg::dword_t bus_read_data,
    output periph_pkg::irq_t    interrupt_vector,
    input  logic                interrupt_ack,
    output logic                UART_TXD,
    output logic [7:0]          LEDG,
    output logic                LEDR0,
    output logic                LEDR1
);

    periph_pkg::byte_t key_code;
    logic              key_make;
    periph_pkg::byte_t last_code;
    logic              key_sel;
    periph_pkg::byte_t tx_byte;
    logic              tx_start;
    logic              tx_busy;

    data_bus_if mem_bus ();

    board_bus_ctrl u_bus_ctrl (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .last_code        (last_code),
        .busy             (tx_busy),
        .bus_read_data    (bus_read_data),
        .key_sel          (key_sel),
        .tx_byte          (tx_byte),
        .tx_start         (tx_start),
        .mem              (mem_bus.master)
    );

    unified_mem u_mem (
        .CLOCK_50 (CLOCK_50),
        .fetch_pc (fetch_pc),
        .instr    (instr),
        .bus      (mem_bus.slave)
    );

    // Release codes are reported but raise no interrupt
    ps2_rx u_ps2_rx (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .PS2_CLK  (PS2_CLK),
        .PS2_DAT  (PS2_DAT),
        .code     (key_code),
        .make     (key_make),
        .brk      ()
    );

    key_irq u_key_irq (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .code             (key_code),
        .make             (key_make),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector),
        .last_code        (last_code)
    );

    uart_tx u_uart_tx (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .UART_TXD (UART_TXD),
        .busy     (tx_busy)
    );

    // Board LEDs
    assign LEDG  = last_code;
    assign LEDR0 = (interrupt_vector != '0);
    assign LEDR1 = key_sel;

endmodule

// ==== design/data_bus_if.sv ====
`timescale 1ns/1ps

interface data_bus_if;

    soc_map_pkg::word_idx_t word_idx;
    soc_map_pkg::word_t     wdata;
    logic                   we;
    logic                   re;
    // Holds the last read word until the next read
    soc_map_pkg::word_t     rdata;

    modport master (
        output word_idx, wdata, we, re,
        input  rdata
    );

    modport slave (
        input  word_idx, wdata, we, re,
        output rdata
    );

endinterface

// ==== design/key_irq.sv ====
`timescale 1ns/1ps

module key_irq (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  periph_pkg::byte_t code,
    input  logic              make,
    input  logic              interrupt_ack,
    output periph_pkg::irq_t  interrupt_vector,
    output periph_pkg::byte_t last_code
);

    logic key_event;

    // A zero code is not a key
    assign key_event = make && (code != '0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= '0;
            last_code        <= '0;
        end else begin
            if (key_event) begin
                last_code        <= code;
                interrupt_vector <= periph_pkg::IRQ_KEY;
            end
            // Acknowledge wins, the vector is raised only once per key
            if (interrupt_vector != '0 && interrupt_ack) begin
                interrupt_vector <= '0;
            end
        end
    end

endmodule

// ==== design/periph_pkg.sv ====
package periph_pkg;

    // Byte carried by the keyboard and the serial line
    typedef logic [7:0] byte_t;

    // Interrupt vector toward the CPU, zero when nothing is pending
    typedef logic [3:0] irq_t;

    // Prefix sent by the keyboard before the code of a released key
    localparam byte_t BREAK_CODE = 8'hF0;

    // Clock cycles per serial bit
    localparam int UART_DIV = 16;

    // Vector raised for a key press
    localparam irq_t IRQ_KEY = 4'd1;

    // PS/2 frame receiver, start bit is seen in idle
    typedef enum logic [1:0] {
        PS2_IDLE,
        PS2_DATA,
        PS2_PARITY,
        PS2_STOP
    } ps2_state_t;

    // 8N1 transmitter
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

// ==== design/ps2_rx.sv ====
`timescale 1ns/1ps

module ps2_rx (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              PS2_CLK,
    input  logic              PS2_DAT,
    output periph_pkg::byte_t code,
    output logic              make,
    output logic              brk
);

    periph_pkg::ps2_state_t state;
    logic [1:0]             clk_sync;
    logic [1:0]             dat_sync;
    logic                   clk_prev;
    logic                   clk_fall;
    logic [2:0]             bit_cnt;
    periph_pkg::byte_t      shreg;
    logic                   par_bit;
    logic                   frame_ok;
    logic                   brk_pending;

    // Two flops on each line, both idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], PS2_CLK};
            dat_sync <= {dat_sync[0], PS2_DAT};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[1];

    // Data bits arrive LSB first
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall && state == periph_pkg::PS2_DATA) begin
            shreg <= {dat_sync[1], shreg[7:1]};
        end
        if (clk_fall && state == periph_pkg::PS2_PARITY) begin
            par_bit <= dat_sync[1];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= periph_pkg::PS2_IDLE;
            bit_cnt  <= '0;
            frame_ok <= 1'b0;
            code     <= '0;
        end else begin
            frame_ok <= 1'b0;
            if (clk_fall) begin
                case (state)
                    periph_pkg::PS2_IDLE: begin
                        if (!dat_sync[1]) begin
                            state   <= periph_pkg::PS2_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    periph_pkg::PS2_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= periph_pkg::PS2_PARITY;
                        end
                    end
                    periph_pkg::PS2_PARITY: begin
                        state <= periph_pkg::PS2_STOP;
                    end
                    default: begin
                        // Odd parity over data and parity bit, stop bit high
                        state <= periph_pkg::PS2_IDLE;
                        if (dat_sync[1] && ^{shreg, par_bit}) begin
                            frame_ok <= 1'b1;
                            code     <= shreg;
                        end
                    end
                endcase
            end
        end
    end

    // Classify the code one cycle after the frame is accepted
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            make        <= 1'b0;
            brk         <= 1'b0;
            brk_pending <= 1'b0;
        end else begin
            make <= 1'b0;
            brk  <= 1'b0;
            if (frame_ok) begin
                if (code == periph_pkg::BREAK_CODE) begin
                    brk_pending <= 1'b1;
                end else if (brk_pending) begin
                    brk         <= 1'b1;
                    brk_pending <= 1'b0;
                end else begin
                    make <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/soc_map_pkg.sv ====
package soc_map_pkg;

    // Bus side of the board, 64-bit byte addresses and data
    typedef logic [63:0] addr_t;
    typedef logic [63:0] dword_t;

    // Memory is organized as 32-bit words
    typedef logic [31:0] word_t;
    typedef logic [10:0] word_idx_t;

    // 2048 words of 4 bytes, 8 KB from address zero
    localparam int MEM_WORDS = 2048;

    // First byte address past the memory
    localparam addr_t MEM_LIMIT = 64'h0000_0000_0000_2000;

    // Last scan code from the keyboard
    localparam addr_t KEY_ADDR = 64'h0000_0000_0000_2000;

    // Serial console output byte, low 8 bits of the write data
    localparam addr_t UART_DATA_ADDR = 64'h0000_0000_0000_2008;

    // Serial transmitter busy flag in bit 0
    localparam addr_t UART_STAT_ADDR = 64'h0000_0000_0000_2010;

endpackage

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  periph_pkg::byte_t tx_byte,
    input  logic              tx_start,
    output logic              UART_TXD,
    output logic              busy
);

    localparam int BAUD_W = $clog2(periph_pkg::UART_DIV);

    periph_pkg::uart_state_t state;
    logic [BAUD_W-1:0]       baud_cnt;
    logic [2:0]              bit_cnt;
    logic                    bit_end;
    periph_pkg::byte_t       shreg;

    assign bit_end = (baud_cnt == BAUD_W'(periph_pkg::UART_DIV - 1));
    assign busy    = (state != periph_pkg::UART_IDLE);

    // Next data bit is always shreg[0]
    always_ff @(posedge CLOCK_50) begin
        if (state == periph_pkg::UART_IDLE && tx_start) begin
            shreg <= tx_byte;
        end else if (bit_end && state != periph_pkg::UART_STOP) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= periph_pkg::UART_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            UART_TXD <= 1'b1;
        end else if (state == periph_pkg::UART_IDLE) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            UART_TXD <= 1'b1;
            if (tx_start) begin
                state    <= periph_pkg::UART_START;
                UART_TXD <= 1'b0;
            end
        end else begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            if (bit_end) begin
                case (state)
                    periph_pkg::UART_START: begin
                        state    <= periph_pkg::UART_DATA;
                        UART_TXD <= shreg[0];
                    end
                    periph_pkg::UART_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state    <= periph_pkg::UART_STOP;
                            UART_TXD <= 1'b1;
                        end else begin
                            UART_TXD <= shreg[0];
                        end
                    end
                    default: begin
                        state <= periph_pkg::UART_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== design/unified_mem.sv ====
`timescale 1ns/1ps

module unified_mem (
    input  logic               CLOCK_50,
    input  soc_map_pkg::addr_t fetch_pc,
    output soc_map_pkg::word_t instr,
    data_bus_if.slave          bus
);

    localparam int IDX_W = $bits(soc_map_pkg::word_idx_t);

    soc_map_pkg::word_t     mem [soc_map_pkg::MEM_WORDS];
    soc_map_pkg::word_idx_t fetch_idx;
    soc_map_pkg::word_t     fetch_q;

    assign fetch_idx = fetch_pc[IDX_W+1:2];

    // Instruction fetch port
    always_ff @(posedge CLOCK_50) begin
        fetch_q <= mem[fetch_idx];
    end

    // Memory holds words big-endian, the core wants them little-endian
    assign instr = {fetch_q[7:0], fetch_q[15:8], fetch_q[23:16], fetch_q[31:24]};

    // Data port, write wins over read
    always_ff @(posedge CLOCK_50) begin
        if (bus.we) begin
            mem[bus.word_idx] <= bus.wdata;
        end else if (bus.re) begin
            bus.rdata <= mem[bus.word_idx];
        end
    end

endmodule

// ==== tb/tb_cpu_on_board.sv ====
`timescale 1ns/1ps

module tb_cpu_on_board;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int PS2_HALF       = 20;
    localparam int BIT_CYCLES     = 16;

    logic                CLOCK_50;
    logic                KEY0;
    logic                PS2_CLK;
    logic                PS2_DAT;
    soc_map_pkg::addr_t  fetch_pc;
    soc_map_pkg::word_t  instr;
    soc_map_pkg::addr_t  bus_address;
    soc_map_pkg::dword_t bus_write_data;
    logic                bus_write_enable;
    logic                bus_read_enable;
    soc_map_pkg::dword_t bus_read_data;
    periph_pkg::irq_t    interrupt_vector;
    logic                interrupt_ack;
    logic                UART_TXD;
    logic [7:0]          LEDG;
    logic                LEDR0;
    logic                LEDR1;

    int                  cycle_count;
    periph_pkg::byte_t   last_key;

    cpu_on_board uut (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .PS2_CLK          (PS2_CLK),
        .PS2_DAT          (PS2_DAT),
        .fetch_pc         (fetch_pc),
        .instr            (instr),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .UART_TXD         (UART_TXD),
        .LEDG             (LEDG),
        .LEDR0            (LEDR0),
        .LEDR1            (LEDR1)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH at %0t: %s = %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    always @(posedge CLOCK_50) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES));
        end
    end

    // Inputs change 2 ns after the rising edge
    task automatic step_cycle();
        @(posedge CLOCK_50);
        #2;
    endtask

    task automatic bus_write(input soc_map_pkg::addr_t addr, input soc_map_pkg::dword_t data);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        step_cycle();
        bus_write_enable = 1'b0;
    endtask

    task automatic bus_read(input soc_map_pkg::addr_t addr, output soc_map_pkg::dword_t data);
        bus_address     = addr;
        bus_read_enable = 1'b1;
        step_cycle();
        bus_read_enable = 1'b0;
        step_cycle();
        data = bus_read_data;
    endtask

    function automatic logic [31:0] byte_reverse(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Keyboard side, data changes while the clock is high
    task automatic ps2_send(input periph_pkg::byte_t data, input logic parity_ok);
        logic [10:0] frame;
        logic        par;
        par = ~^data;
        if (!parity_ok) begin
            par = ~par;
        end
        frame = {1'b1, par, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            PS2_DAT = frame[i];
            repeat (PS2_HALF) step_cycle();
            PS2_CLK = 1'b0;
            repeat (PS2_HALF) step_cycle();
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
    endtask

    // Finds the start bit, then samples each bit in its middle
    task automatic uart_expect(input periph_pkg::byte_t data);
        int n;
        n = 0;
        while (UART_TXD !== 1'b0 && n < 50) begin
            step_cycle();
            n++;
        end
        if (UART_TXD !== 1'b0) begin
            abort_run("No start bit appeared on UART_TXD after the serial write");
        end
        repeat (BIT_CYCLES / 2) step_cycle();
        check_value("UART_TXD start bit", UART_TXD, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) step_cycle();
            check_value($sformatf("UART_TXD data bit %0d", i), UART_TXD, data[i]);
        end
        repeat (BIT_CYCLES) step_cycle();
        check_value("UART_TXD stop bit", UART_TXD, 1'b1);
    endtask

    task automatic test_memory();
        logic [31:0]         rnd;
        logic [31:0]         data;
        soc_map_pkg::addr_t  addr;
        soc_map_pkg::dword_t rd;
        for (int i = 0; i < 16; i++) begin
            rnd  = $urandom;
            data = $urandom;
            addr = {51'd0, rnd[10:0], 2'b00};
            bus_write(addr, {$urandom, data});
            bus_read(addr, rd);
            check_value("bus_read_data", rd, {32'd0, data});
        end
    endtask

    task automatic test_fetch();
        logic [31:0]        rnd;
        logic [31:0]        data;
        soc_map_pkg::addr_t addr;
        for (int i = 0; i < 4; i++) begin
            rnd  = $urandom;
            data = $urandom;
            addr = {51'd0, rnd[10:0], 2'b00};
            bus_write(addr, {32'd0, data});
            fetch_pc = addr;
            step_cycle();
            step_cycle();
            check_value("instr", instr, byte_reverse(data));
        end
    endtask

    task automatic test_key_make(input periph_pkg::byte_t code);
        soc_map_pkg::dword_t rd;
        int                  n;
        ps2_send(code, 1'b1);
        n = 0;
        while (interrupt_vector == '0 && n < 50) begin
            step_cycle();
            n++;
        end
        if (interrupt_vector == '0) begin
            abort_run("No keyboard interrupt was raised after a make code");
        end
        last_key = code;
        check_value("interrupt_vector", interrupt_vector, 4'd1);
        check_value("LEDG", LEDG, code);
        check_value("LEDR0", LEDR0, 1'b1);
        bus_read(soc_map_pkg::KEY_ADDR, rd);
        check_value("bus_read_data", rd, {56'd0, code});
        check_value("LEDR1", LEDR1, 1'b1);
        // Vector stays up until the CPU acknowledges
        check_value("interrupt_vector", interrupt_vector, 4'd1);
        interrupt_ack = 1'b1;
        step_cycle();
        interrupt_ack = 1'b0;
        step_cycle();
        check_value("interrupt_vector", interrupt_vector, 4'd0);
        check_value("LEDR0", LEDR0, 1'b0);
    endtask

    task automatic test_no_irq(input periph_pkg::byte_t code, input logic parity_ok);
        ps2_send(code, parity_ok);
        repeat (50) step_cycle();
        check_value("interrupt_vector", interrupt_vector, 4'd0);
        check_value("LEDG", LEDG, last_key);
    endtask

    task automatic test_uart(input periph_pkg::byte_t data, input periph_pkg::byte_t second);
        soc_map_pkg::dword_t rd;
        int                  n;
        fork
            uart_expect(data);
            begin
                bus_write(soc_map_pkg::UART_DATA_ADDR, {56'd0, data});
                repeat (20) step_cycle();
                bus_read(soc_map_pkg::UART_STAT_ADDR, rd);
                check_value("bus_read_data busy", rd, 64'd1);
                // Lands in the middle of the frame and must be lost
                bus_write(soc_map_pkg::UART_DATA_ADDR, {56'd0, second});
            end
        join
        n = 0;
        rd = 64'd1;
        while (rd[0] && n < 40) begin
            bus_read(soc_map_pkg::UART_STAT_ADDR, rd);
            n++;
        end
        if (rd[0]) begin
            abort_run("Serial busy flag never cleared after the frame");
        end
        check_value("bus_read_data busy", rd, 64'd0);
        repeat (200) begin
            step_cycle();
            check_value("UART_TXD idle", UART_TXD, 1'b1);
        end
    endtask

    task automatic test_unmapped();
        soc_map_pkg::dword_t rd;
        bus_write(64'h40, 64'h0000_0000_dead_beef);
        bus_read(64'h40, rd);
        check_value("bus_read_data", rd, 64'h0000_0000_dead_beef);
        bus_read(64'h3000, rd);
        check_value("bus_read_data unmapped", rd, 64'd0);
        bus_read(64'h2018, rd);
        check_value("bus_read_data unmapped", rd, 64'd0);
    endtask

    initial begin
        void'($urandom(32'haeec64d5));
        cycle_count      = 0;
        last_key         = '0;
        KEY0             = 1'b0;
        PS2_CLK          = 1'b1;
        PS2_DAT          = 1'b1;
        fetch_pc         = '0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        interrupt_ack    = 1'b0;

        repeat (4) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
        step_cycle();

        check_value("interrupt_vector", interrupt_vector, 4'd0);
        check_value("UART_TXD", UART_TXD, 1'b1);
        check_value("LEDG", LEDG, 8'd0);

        test_memory();
        test_fetch();
        test_key_make(8'h1C);
        // Release of the same key
        ps2_send(periph_pkg::BREAK_CODE, 1'b1);
        test_no_irq(8'h1C, 1'b1);
        test_no_irq(8'h33, 1'b0);
        test_no_irq(8'h00, 1'b1);
        test_key_make(8'h15);
        test_uart(8'hA5, 8'h3C);
        test_unmapped();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
design/soc_map_pkg.sv
design/periph_pkg.sv
design/data_bus_if.sv
design/board_bus_ctrl.sv
design/unified_mem.sv
design/ps2_rx.sv
design/key_irq.sv
design/uart_tx.sv
design/cpu_on_board.sv
tb/tb_cpu_on_board.sv
